// ==== logic/sd_spi_settings.svh ====
`ifndef SD_SPI_SETTINGS_SVH
`define SD_SPI_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////
// register map
////////////////////////////////////////////////////////////////////////

`define SD_ADR_W 3

`define SD_REG_CTRL    3'd0
`define SD_REG_DATA    3'd1
`define SD_REG_DMA_LEN 3'd2
`define SD_REG_DMA_CTL 3'd3
`define SD_REG_FIFO    3'd4

// receive fifo entries
`define SD_FIFO_DEPTH 16

// system clocks per half sdclk, fixed speed
`define SD_SCK_DIV 2

`endif

// ==== logic/sd_spi_pkg.sv ====
`include "sd_spi_settings.svh"

package sd_spi_pkg;

	// wishbone classic request from the master
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [`SD_ADR_W-1:0] adr;
		logic [7:0]           dat;
	} wb_req_t;

	// one byte to shift, held until its done comes back
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} spi_req_t;

	// owner 0 is the cpu, 1 is dma
	typedef struct packed {
		logic       done;
		logic       owner;
		logic [7:0] data;
	} spi_rsp_t;

	typedef struct packed {
		logic       start;
		logic [7:0] len;
		logic       pop;
	} dma_cmd_t;

	typedef struct packed {
		logic       busy;
		logic       nonempty;
		logic [7:0] head;
	} dma_stat_t;

endpackage

// ==== logic/sd_cpu_port.sv ====
`timescale 1ns/100ps
`include "sd_spi_settings.svh"

module sd_cpu_port
	import sd_spi_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	input  wb_req_t    wb_req,
	output logic [7:0] wb_dat_r,
	output logic       wb_ack,

	output spi_req_t   cpu_spi,
	input  spi_rsp_t   spi_rsp,

	output dma_cmd_t   dma_cmd,
	input  dma_stat_t  dma_stat,

	output logic       sdcs_n
);

	logic       access;
	logic       cpu_done;
	logic       cpu_valid;
	logic [7:0] cpu_byte;
	logic [7:0] rx_byte;
	logic [7:0] dma_len;
	logic       dma_start;
	logic       dma_pop;
	logic [7:0] rd_data;

	// new cycle, not the ack cycle and not a data write still shifting
	assign access = wb_req.cyc & wb_req.stb & ~wb_ack & ~cpu_valid;
	assign cpu_done = spi_rsp.done & ~spi_rsp.owner;

	assign cpu_spi = '{valid: cpu_valid, data: cpu_byte};
	assign dma_cmd = '{start: dma_start, len: dma_len, pop: dma_pop};

	////////////////////////////////////////////////////////////////////
	// register decode
	////////////////////////////////////////////////////////////////////

	always_comb begin
		case (wb_req.adr)
			`SD_REG_CTRL:    rd_data = {7'd0, sdcs_n};
			`SD_REG_DATA:    rd_data = rx_byte;
			`SD_REG_DMA_LEN: rd_data = dma_len;
			`SD_REG_DMA_CTL: rd_data = {6'd0, dma_stat.nonempty, dma_stat.busy};
			`SD_REG_FIFO:    rd_data = dma_stat.nonempty ? dma_stat.head : 8'hFF;
			default:         rd_data = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack    <= 1'b0;
			sdcs_n    <= 1'b1;
			cpu_valid <= 1'b0;
			dma_len   <= 8'd0;
			dma_start <= 1'b0;
			dma_pop   <= 1'b0;
		end else begin
			wb_ack    <= 1'b0;
			dma_start <= 1'b0;
			dma_pop   <= 1'b0;

			// data write acks the cycle after its byte is done
			if (cpu_done && cpu_valid) begin
				cpu_valid <= 1'b0;
				wb_ack    <= 1'b1;
			end

			if (access) begin
				if (wb_req.we) begin
					wb_ack <= (wb_req.adr != `SD_REG_DATA);
					case (wb_req.adr)
						`SD_REG_CTRL:    sdcs_n <= wb_req.dat[0];
						`SD_REG_DATA:    cpu_valid <= 1'b1;
						`SD_REG_DMA_LEN: dma_len <= wb_req.dat;
						// bit 0 starts a burst, ignored while one runs
						`SD_REG_DMA_CTL: dma_start <= wb_req.dat[0] & ~dma_stat.busy;
						default: ;
					endcase
				end else begin
					wb_ack  <= 1'b1;
					dma_pop <= (wb_req.adr == `SD_REG_FIFO) & dma_stat.nonempty;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access && wb_req.we && wb_req.adr == `SD_REG_DATA)
			cpu_byte <= wb_req.dat;
		if (access && !wb_req.we)
			wb_dat_r <= rd_data;
		if (cpu_done)
			rx_byte <= spi_rsp.data;
	end

endmodule

// ==== logic/sd_dma_channel.sv ====
`timescale 1ns/100ps
`include "sd_spi_settings.svh"

module sd_dma_channel
	import sd_spi_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  dma_cmd_t  dma_cmd,
	output dma_stat_t dma_stat,

	output spi_req_t  dma_spi,
	input  spi_rsp_t  spi_rsp
);

	localparam int DEPTH = `SD_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic             busy;
	logic [8:0]       left;
	logic             req_q;
	logic             push;
	logic             pop;
	logic             full;
	logic [7:0]       mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;

	assign push = spi_rsp.done & spi_rsp.owner;
	assign pop  = dma_cmd.pop & (fill != '0);
	assign full = (fill == CNT_W'(DEPTH));

	// dummy 0xff clocks the card's data out
	assign dma_spi  = '{valid: req_q, data: 8'hFF};
	assign dma_stat = '{busy: busy, nonempty: (fill != '0), head: mem[rd_ptr]};

	////////////////////////////////////////////////////////////////////
	// burst control
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			left  <= 9'd0;
			req_q <= 1'b0;
		end else if (dma_cmd.start && !busy) begin
			busy <= 1'b1;
			// length 0 means 256
			left <= (dma_cmd.len == 8'd0) ? 9'd256 : {1'b0, dma_cmd.len};
		end else if (push) begin
			req_q <= 1'b0;
			left  <= left - 9'd1;
			if (left == 9'd1)
				busy <= 1'b0;
		end else if (busy && !req_q && !full) begin
			req_q <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////
	// receive fifo
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= spi_rsp.data;
	end

endmodule

// ==== logic/spi_shifter.sv ====
`timescale 1ns/100ps
`include "sd_spi_settings.svh"

module spi_shifter
	import sd_spi_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,

	input  spi_req_t cpu_spi,
	input  spi_req_t dma_spi,
	output spi_rsp_t spi_rsp,

	output logic     sdclk,
	output logic     sddo,
	input  logic     sddi
);

	localparam int DIV   = `SD_SCK_DIV;
	localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic             active;
	logic             owner;
	logic             done;
	logic             sclk;
	logic             half_end;
	logic [DIV_W-1:0] dcnt;
	logic [2:0]       bcnt;
	logic [7:0]       tx;
	logic [7:0]       rx;

	assign half_end = (dcnt == DIV_W'(DIV - 1));

	assign sdclk   = sclk;
	assign sddo    = tx[7];
	assign spi_rsp = '{done: done, owner: owner, data: rx};

	////////////////////////////////////////////////////////////////////
	// arbitration and shift, mode 0, msb first
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
			owner  <= 1'b0;
			done   <= 1'b0;
			sclk   <= 1'b0;
			dcnt   <= '0;
			bcnt   <= 3'd0;
			tx     <= 8'hFF;
		end else begin
			done <= 1'b0;
			if (!active) begin
				dcnt <= '0;
				bcnt <= 3'd0;
				// requester still holds valid in the done cycle
				if (!done && (cpu_spi.valid || dma_spi.valid)) begin
					active <= 1'b1;
					owner  <= ~cpu_spi.valid;
					tx     <= cpu_spi.valid ? cpu_spi.data : dma_spi.data;
				end
			end else if (half_end) begin
				dcnt <= '0;
				sclk <= ~sclk;
				// falling edge moves to the next bit
				if (sclk) begin
					if (bcnt == 3'd7) begin
						active <= 1'b0;
						done   <= 1'b1;
						tx     <= 8'hFF;
					end else begin
						bcnt <= bcnt + 3'd1;
						tx   <= {tx[6:0], 1'b1};
					end
				end
			end else begin
				dcnt <= dcnt + 1'b1;
			end
		end
	end

	// sample on the rising edge
	always_ff @(posedge clk) begin
		if (active && half_end && !sclk)
			rx <= {rx[6:0], sddi};
	end

endmodule

// ==== logic/sd_spi_top.sv ====
`timescale 1ns/100ps

module sd_spi_top
	import sd_spi_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// wishbone slave
	input  wb_req_t    wb_req,
	output logic [7:0] wb_dat_r,
	output logic       wb_ack,

	// sd card
	output logic       sdcs_n,
	output logic       sdclk,
	output logic       sddo,
	input  logic       sddi
);

	spi_req_t  cpu_spi;
	spi_req_t  dma_spi;
	spi_rsp_t  spi_rsp;
	dma_cmd_t  dma_cmd;
	dma_stat_t dma_stat;

	sd_cpu_port u_cpu_port (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_req   (wb_req),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.cpu_spi  (cpu_spi),
		.spi_rsp  (spi_rsp),
		.dma_cmd  (dma_cmd),
		.dma_stat (dma_stat),
		.sdcs_n   (sdcs_n)
	);

	sd_dma_channel u_dma_channel (
		.clk      (clk),
		.rst_n    (rst_n),
		.dma_cmd  (dma_cmd),
		.dma_stat (dma_stat),
		.dma_spi  (dma_spi),
		.spi_rsp  (spi_rsp)
	);

	// one shifter, two requesters
	spi_shifter u_spi_shifter (
		.clk     (clk),
		.rst_n   (rst_n),
		.cpu_spi (cpu_spi),
		.dma_spi (dma_spi),
		.spi_rsp (spi_rsp),
		.sdclk   (sdclk),
		.sddo    (sddo),
		.sddi    (sddi)
	);

endmodule

// ==== verif/sd_spi_checker.sv ====
`timescale 1ns/100ps

module sd_spi_checker (
	input logic       clk,
	input logic       wb_ack,
	input logic [7:0] wb_dat_r,
	input logic       sdclk,
	input logic       sddo
);

	logic [7:0] last_rd;
	logic [7:0] sent;
	int         errors;
	int         test_errs;
	int         checks;
	int         tests;
	int         dma_count;

	initial begin
		last_rd   = 8'h00;
		sent      = 8'h00;
		errors    = 0;
		test_errs = 0;
		checks    = 0;
		tests     = 0;
		dma_count = 0;
	end

	// read data settles with ack, taken mid cycle
	always @(negedge clk) begin
		if (wb_ack)
			last_rd = wb_dat_r;
	end

	// mode 0, card side samples on the rising edge
	always @(posedge sdclk) begin
		sent = {sent[6:0], sddo};
	end

	task automatic mismatch(input string name, input logic [8:0] exp, input logic [8:0] act);
		$display("Fail %s: expected %0h, got %0h", name, exp, act);
		errors++;
		test_errs++;
	endtask

	task automatic check_read(input string name, input logic [7:0] exp);
		checks++;
		if (last_rd !== exp)
			mismatch(name, {1'b0, exp}, {1'b0, last_rd});
	endtask

	task automatic check_sent(input logic [7:0] exp, input logic is_dma);
		checks++;
		if (is_dma)
			dma_count++;
		if (sent !== exp)
			mismatch("sddo", {1'b0, exp}, {1'b0, sent});
	endtask

	task automatic check_count(input logic [8:0] exp);
		checks++;
		if (dma_count != int'(exp))
			mismatch("dma byte count", exp, 9'(dma_count));
	endtask

	task automatic plain_error(input string what);
		$display("error: %s", what);
		errors++;
		test_errs++;
	endtask

	task automatic end_test(input int num);
		tests++;
		if (test_errs == 0)
			$display("test %0d: pass", num);
		else
			$display("test %0d: %0d mismatches", num, test_errs);
		test_errs = 0;
	endtask

	task automatic report();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
	endtask

endmodule

// ==== verif/sd_spi_sva.sv ====
`timescale 1ns/100ps

module sd_spi_sva
	import sd_spi_pkg::*;
(
	input logic    clk,
	input logic    rst_n,
	input wb_req_t wb_req,
	input logic    wb_ack,
	input logic    sdcs_n,
	input logic    sdclk
);

	int fails;

	initial fails = 0;

	// ack only while the master still strobes
	ack_with_stb: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> wb_req.cyc && wb_req.stb)
		else begin
			fails++;
			$error("wb_ack raised without a strobe");
		end

	ack_single: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else begin
			fails++;
			$error("wb_ack held for two cycles");
		end

	// no clocks to the card while deselected
	sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
		sdcs_n |-> !sdclk)
		else begin
			fails++;
			$error("sdclk toggled with sdcs_n high");
		end

endmodule

bind sd_spi_top sd_spi_sva u_sva (
	.clk    (clk),
	.rst_n  (rst_n),
	.wb_req (wb_req),
	.wb_ack (wb_ack),
	.sdcs_n (sdcs_n),
	.sdclk  (sdclk)
);

// ==== verif/sd_spi_tb.sv ====
`timescale 1ns/100ps
`include "sd_spi_settings.svh"

module sd_spi_tb
	import sd_spi_pkg::*;
;

	logic       clk;
	logic       rst_n;
	wb_req_t    wb_req;
	logic [7:0] wb_dat_r;
	logic       wb_ack;
	logic       sdcs_n;
	logic       sdclk;
	logic       sddo;
	logic       sddi;

	logic [31:0] vec [64];
	logic [15:0] lfsr;
	logic [7:0]  exp_fifo [$];
	logic [7:0]  cpu_sent;
	logic [7:0]  cpu_reply;
	logic [7:0]  card_tx;
	logic        card_dma;
	int          card_bits;
	int          cycles;
	int          limit;

	sd_spi_top u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_req   (wb_req),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.sdcs_n   (sdcs_n),
		.sdclk    (sdclk),
		.sddo     (sddo),
		.sddi     (sddi)
	);

	sd_spi_checker u_chk (
		.clk      (clk),
		.wb_ack   (wb_ack),
		.wb_dat_r (wb_dat_r),
		.sdclk    (sdclk),
		.sddo     (sddo)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (limit != 0 && cycles > limit) begin
			$display("timeout: run still going after %0d cycles", limit);
			$display("Checks failed");
			$finish;
		end
	end

	// galois lfsr stepped once per card bit
	function automatic logic [7:0] lfsr_byte();
		logic [7:0] b;
		b = 8'h00;
		for (int k = 0; k < 8; k++) begin
			b = {b[6:0], lfsr[0]};
			lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
		end
		return b;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// sd card model
	//////////////////////////////////////////////////////////////////////

	always @(posedge u_dut.u_spi_shifter.active) begin
		#10;
		card_dma = u_dut.u_spi_shifter.owner;
		if (sdcs_n)
			card_tx = 8'hFF;
		else if (card_dma) begin
			card_tx = lfsr_byte();
			exp_fifo.push_back(card_tx);
		end else
			card_tx = cpu_reply;
		sddi = card_tx[7];
		card_bits = 0;
	end

	always @(negedge sdclk) begin
		#10;
		card_bits++;
		card_tx = {card_tx[6:0], 1'b1};
		sddi = card_tx[7];
		if (card_bits == 8)
			u_chk.check_sent(card_dma ? 8'hFF : cpu_sent, card_dma);
	end

	//////////////////////////////////////////////////////////////////////
	// wishbone master
	//////////////////////////////////////////////////////////////////////

	task automatic wb_access(input logic we, input logic [2:0] a, input logic [7:0] d);
		@(posedge clk);
		#10;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: a, dat: d};
		do begin
			@(posedge clk);
			#10;
		end while (!wb_ack);
		// strobe ends in the cycle after ack
		@(posedge clk);
		#10;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		@(negedge clk);
		#1;
	endtask

	task automatic fifo_read_check();
		logic [7:0] exp;
		do
			wb_access(1'b0, `SD_REG_DMA_CTL, 8'h00);
		while (!u_chk.last_rd[1]);
		wb_access(1'b0, `SD_REG_FIFO, 8'h00);
		if (exp_fifo.size() == 0)
			u_chk.plain_error("fifo returned a byte the card never sent");
		else begin
			exp = exp_fifo.pop_front();
			u_chk.check_read("wb_dat_r", exp);
		end
	endtask

	task automatic wait_idle();
		do
			wb_access(1'b0, `SD_REG_DMA_CTL, 8'h00);
		while (u_chk.last_rd[0]);
	endtask

	initial begin
		logic [7:0] op;
		logic [7:0] adr;
		logic [7:0] dat;
		logic [7:0] expv;
		int         n;
		int         burst_bytes;

		wb_req    = '0;
		sddi      = 1'b1;
		rst_n     = 1'b0;
		lfsr      = 16'd45089;
		cpu_sent  = 8'hFF;
		cpu_reply = 8'hFF;
		card_tx   = 8'hFF;
		card_dma  = 1'b0;
		card_bits = 0;
		cycles    = 0;
		limit     = 0;
		for (int k = 0; k < 64; k++)
			vec[k] = 32'hFF00_0000;
		$readmemh("verif/sd_spi_vectors.txt", vec);

		// budget from the vector lengths
		n = 0;
		burst_bytes = 0;
		while (n < 64 && vec[n][31:24] != 8'hFF) begin
			if (vec[n][31:24] == 8'h04)
				burst_bytes += (vec[n][15:8] == 8'd0) ? 256 : int'(vec[n][15:8]);
			n++;
		end
		limit = 20 + 64 * (n + 1) + 40 * burst_bytes;

		repeat (10) @(posedge clk);
		#10;
		rst_n = 1'b1;

		for (int k = 0; k < n; k++) begin
			{op, adr, dat, expv} = vec[k];
			case (op)
				8'h01: wb_access(1'b1, adr[2:0], dat);
				8'h02: begin
					wb_access(1'b0, adr[2:0], 8'h00);
					u_chk.check_read("wb_dat_r", expv);
				end
				8'h03: begin
					cpu_sent  = dat;
					cpu_reply = expv;
					wb_access(1'b1, `SD_REG_DATA, dat);
				end
				8'h04: begin
					u_chk.dma_count = 0;
					wb_access(1'b1, `SD_REG_DMA_LEN, dat);
					wb_access(1'b1, `SD_REG_DMA_CTL, 8'h01);
				end
				8'h05: begin
					for (int r = 0; r < int'(dat); r++)
						fifo_read_check();
				end
				8'h06: wait_idle();
				8'h07: begin
					while (u_chk.dma_count < int'(dat))
						@(posedge clk);
					// full fifo must hold the burst
					repeat (100) @(posedge clk);
					u_chk.check_count({1'b0, dat});
				end
				8'h08: u_chk.check_count({1'b0, dat});
				8'h0F: u_chk.end_test(int'(dat));
				default: u_chk.plain_error("unknown operation in the vector file");
			endcase
		end

		u_chk.report();
		if (u_chk.errors == 0 && u_dut.u_sva.fails == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/sd_spi_pkg.sv
logic/sd_cpu_port.sv
logic/sd_dma_channel.sv
logic/spi_shifter.sv
logic/sd_spi_top.sv
verif/sd_spi_checker.sv
verif/sd_spi_sva.sv
verif/sd_spi_tb.sv

// ==== Makefile ====
# Verilator build and run for the SD SPI testbench

VERILATOR ?= verilator
TOP       ?= sd_spi_tb
FILELIST  ?= filelist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

PASS_TEXT := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "result: pass" || \
		(echo "result: fail"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verif/sd_spi_vectors.txt ====
// op_adr_dat_exp, op: 01 write, 02 read and compare, 03 cpu byte (dat sent, exp = card reply)
// 04 burst of dat bytes, 05 dat fifo reads, 06 wait idle, 07 stall at dat, 08 burst total, 0f end test
02_00_00_01
02_03_00_00
02_04_00_ff
0f_00_01_00
01_00_00_00
03_00_5a_c3
02_01_00_c3
0f_00_02_00
04_00_08_00
06_00_00_00
08_00_08_00
05_00_08_00
02_03_00_00
0f_00_03_00
04_00_14_00
07_00_10_00
05_00_14_00
06_00_00_00
08_00_14_00
02_03_00_00
0f_00_04_00
04_00_06_00
03_00_a5_3c
02_01_00_3c
06_00_00_00
05_00_06_00
0f_00_05_00
04_00_04_00
01_03_01_00
06_00_00_00
08_00_04_00
05_00_04_00
02_04_00_ff
0f_00_06_00
ff_00_00_00
